// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= regAluTb
FILELIST ?= all.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
FAILMSG ?= STATUS: FAIL

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

sim: build
	@./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if grep -q "$(FAILMSG)" $(LOG) || [ $$rc -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== all.f ====
regAluPkg.sv
switchCapture.sv
regFile.sv
operandFetch.sv
aluExec.sv
hexDisplay.sv
regAluTop.sv
regAlu_checker.sv
regAluTb.sv

// ==== aluExec.sv ====
module aluExec (
	input logic clk,
	input logic rstN,
	input logic opValid,
	input regAluPkg::exOperands_t ops,
	input logic resultReady,
	output logic opReady,
	output logic wrEn,
	output logic [regAluPkg::regAddrW-1:0] wrAddr,
	output logic [regAluPkg::dataW-1:0] wrData,
	output logic resultValid,
	output regAluPkg::aluResult_t result
);
	import regAluPkg::*;

	logic [dataW:0] sumExt;      // Extra bit holds carry
	logic [dataW:0] diffExt;     // Extra bit holds borrow
	logic [dataW-1:0] aluValue;
	logic [flagW-1:0] aluFlags;
	logic opTake;
	logic doWrite;

	assign sumExt = {1'b0, ops.a} + {1'b0, ops.b};
	assign diffExt = {1'b0, ops.a} - {1'b0, ops.b};

	// Result value
	always_comb begin
		case (ops.op)
			ADD: aluValue = sumExt[dataW-1:0];
			SUB: aluValue = diffExt[dataW-1:0];
			CMP: aluValue = diffExt[dataW-1:0];   // Only feeds flagZ
			AND: aluValue = ops.a & ops.b;
			OR: aluValue = ops.a | ops.b;
			XOR: aluValue = ops.a ^ ops.b;
			NOT: aluValue = ~ops.b;
			LSH: aluValue = ops.a << ops.b[3:0];
			RSH: aluValue = ops.a >> ops.b[3:0];
			default: aluValue = ops.b;            // MOV and spare codes
		endcase
	end

	// Flags for every op
	always_comb begin
		aluFlags = '0;
		case (ops.op)
			ADD: begin
				aluFlags[flagC] = sumExt[dataW];
				// Like signs in, other sign out
				aluFlags[flagF] = (ops.a[dataW-1] == ops.b[dataW-1]) &&
					(sumExt[dataW-1] != ops.a[dataW-1]);
			end
			SUB: begin
				aluFlags[flagC] = diffExt[dataW];
				aluFlags[flagF] = (ops.a[dataW-1] != ops.b[dataW-1]) &&
					(diffExt[dataW-1] != ops.a[dataW-1]);
			end
			default: ;   // No carry or overflow
		endcase
		aluFlags[flagL] = ops.a < ops.b;
		aluFlags[flagZ] = (aluValue == '0);
		aluFlags[flagN] = $signed(ops.a) < $signed(ops.b);
	end

	// Accept when output slot frees up this cycle
	assign opReady = !resultValid || resultReady;
	assign opTake = opValid && opReady;
	assign doWrite = (ops.op != CMP);

	// Write-back on the acceptance edge
	assign wrEn = opTake && doWrite;
	assign wrAddr = ops.rdest;
	assign wrData = aluValue;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			resultValid <= 1'b0;
		end else if (opTake) begin
			resultValid <= 1'b1;
		end else if (resultReady) begin
			resultValid <= 1'b0;
		end
	end

	// Held while the sink stalls
	always_ff @(posedge clk) begin
		if (opTake) begin
			result.rdest <= ops.rdest;
			result.value <= aluValue;
			result.flags <= aluFlags;
			result.writeEn <= doWrite;
		end
	end

endmodule

// ==== hexDisplay.sv ====
module hexDisplay (
	input logic clk,
	input logic rstN,
	input logic wrEn,
	input logic [regAluPkg::dataW-1:0] wrData,
	output logic [regAluPkg::dataW-1:0] shownValue,
	output logic [6:0] seg3,    // Most significant nibble
	output logic [6:0] seg2,
	output logic [6:0] seg1,
	output logic [6:0] seg0
);
	import regAluPkg::*;

	// Nibble to gfedcba, lit segment drives low
	function automatic logic [6:0] hexSeg(input logic [3:0] nib);
		case (nib)
			4'h0: hexSeg = ~7'b0111111;
			4'h1: hexSeg = ~7'b0000110;
			4'h2: hexSeg = ~7'b1011011;
			4'h3: hexSeg = ~7'b1001111;
			4'h4: hexSeg = ~7'b1100110;
			4'h5: hexSeg = ~7'b1101101;
			4'h6: hexSeg = ~7'b1111101;
			4'h7: hexSeg = ~7'b0000111;
			4'h8: hexSeg = ~7'b1111111;
			4'h9: hexSeg = ~7'b1100111;
			4'hA: hexSeg = ~7'b1110111;
			4'hB: hexSeg = ~7'b1111100;  // Lower case b
			4'hC: hexSeg = ~7'b1011000;  // Lower case c
			4'hD: hexSeg = ~7'b1011110;  // Lower case d
			4'hE: hexSeg = ~7'b1111001;
			default: hexSeg = ~7'b1110001;  // F
		endcase
	endfunction

	// Last value written to the register file
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) shownValue <= '0;
		else if (wrEn) shownValue <= wrData;   // CMP leaves it alone
	end

	assign seg3 = hexSeg(shownValue[dataW-1 -: 4]);
	assign seg2 = hexSeg(shownValue[11:8]);
	assign seg1 = hexSeg(shownValue[7:4]);
	assign seg0 = hexSeg(shownValue[3:0]);

endmodule

// ==== operandFetch.sv ====
module operandFetch (
	input logic clk,
	input logic rstN,
	input logic cmdValid,
	input regAluPkg::aluCmd_t cmd,
	input logic opReady,
	input logic [regAluPkg::dataW-1:0] rdDataA,
	input logic [regAluPkg::dataW-1:0] rdDataB,
	input logic wrEn,                                // Write port of execute
	input logic [regAluPkg::regAddrW-1:0] wrAddr,
	input logic [regAluPkg::dataW-1:0] wrData,
	output logic cmdReady,
	output logic [regAluPkg::regAddrW-1:0] rdAddrA,
	output logic [regAluPkg::regAddrW-1:0] rdAddrB,
	output logic opValid,
	output regAluPkg::exOperands_t ops
);
	import regAluPkg::*;

	logic [dataW-1:0] destVal;
	logic [dataW-1:0] srcVal;
	logic cmdTake;

	// Register addresses come straight from the pending command
	assign rdAddrA = cmd.rdest;
	assign rdAddrB = cmd.rsrc;

	// Bypass of the write that lands on this edge
	always_comb begin
		destVal = rdDataA;
		srcVal = rdDataB;
		if (wrEn && (wrAddr == cmd.rdest)) destVal = wrData;
		if (wrEn && (wrAddr == cmd.rsrc)) srcVal = wrData;
	end

	// Free when empty or when execute drains us this cycle
	assign cmdReady = !opValid || opReady;
	assign cmdTake = cmdValid && cmdReady;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			opValid <= 1'b0;
		end else if (cmdTake) begin
			opValid <= 1'b1;
		end else if (opReady) begin
			opValid <= 1'b0;     // Word taken, nothing new
		end
	end

	// Operand word
	always_ff @(posedge clk) begin
		if (cmdTake) begin
			ops.op <= cmd.op;
			ops.rdest <= cmd.rdest;
			ops.a <= destVal;
			ops.b <= cmd.immSel ? cmd.imm : srcVal;  // Immediate replaces source
		end
	end

endmodule

// ==== regAluPkg.sv ====
package regAluPkg;

	// Datapath and board widths
	localparam int dataW = 16;     // Register and ALU width
	localparam int swW = 10;       // Slide switch word
	localparam int regAddrW = 4;   // Sixteen registers
	localparam int numRegs = 1 << regAddrW;
	localparam int flagW = 5;

	// Bit positions inside a flag word
	localparam int flagC = 0;  // Carry out of ADD or borrow of SUB
	localparam int flagL = 1;  // Unsigned dest below source
	localparam int flagF = 2;  // Signed overflow of ADD or SUB
	localparam int flagZ = 3;  // Result zero
	localparam int flagN = 4;  // Signed dest below source

	// Opcode as set on switch bits 3:0
	typedef enum logic [3:0] {
		ADD = 4'h0,
		SUB = 4'h1,   // Dest minus source
		AND = 4'h2,
		OR  = 4'h3,
		XOR = 4'h4,
		NOT = 4'h5,   // Inverts the source only
		LSH = 4'h6,   // Shift amount from source bits 3:0
		RSH = 4'h7,   // Logical, zero fill
		MOV = 4'h8,
		CMP = 4'h9    // Flags only
	} aluOp_t;        // Codes above CMP behave as MOV

	// Issue state of the capture stage
	typedef enum logic {
		IDLE,
		PENDING
	} captState_t;

	// Capture to fetch, 29 bits
	typedef struct packed {
		aluOp_t op;
		logic immSel;                 // Source comes from imm
		logic [regAddrW-1:0] rdest;
		logic [regAddrW-1:0] rsrc;
		logic [dataW-1:0] imm;        // Switch word in the upper bits
	} aluCmd_t;

	// Fetch to execute, 40 bits
	typedef struct packed {
		aluOp_t op;
		logic [regAddrW-1:0] rdest;
		logic [dataW-1:0] a;          // Destination value
		logic [dataW-1:0] b;          // Source value or immediate
	} exOperands_t;

	// Output word, 26 bits
	typedef struct packed {
		logic [regAddrW-1:0] rdest;
		logic [dataW-1:0] value;
		logic [flagW-1:0] flags;
		logic writeEn;                // Low for CMP
	} aluResult_t;

endpackage

// ==== regAluTb.sv ====
module regAluTb;
	import regAluPkg::*;

	localparam int numIssued = 55;        // 5 + 6 + 11 + 3 + 30 instructions
	localparam int cyclesPerInstr = 50;   // Four presses of nine cycles plus the pop

	logic clk;
	logic rstN;
	logic [swW-1:0] dataIn;
	logic ldReg;
	logic ldSetup;
	logic ldImm;
	logic ldInst;
	logic resultReady;
	logic resultValid;
	aluResult_t result;
	logic [6:0] seg3;
	logic [6:0] seg2;
	logic [6:0] seg1;
	logic [6:0] seg0;

	typedef struct packed {
		aluResult_t res;
		logic [dataW-1:0] shown;   // Display value while this result waits
	} expEntry_t;

	logic [dataW-1:0] model [numRegs];   // Reference register contents
	logic [dataW-1:0] shownModel;
	expEntry_t pending[$];               // Issued, not yet popped
	logic [31:0] lfsrState;

	regAluTop uut (
		.clk(clk),
		.rstN(rstN),
		.dataIn(dataIn),
		.ldReg(ldReg),
		.ldSetup(ldSetup),
		.ldImm(ldImm),
		.ldInst(ldInst),
		.resultReady(resultReady),
		.resultValid(resultValid),
		.result(result),
		.seg3(seg3),
		.seg2(seg2),
		.seg1(seg1),
		.seg0(seg0)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic valueError(input string what, input logic [31:0] got, input logic [31:0] exp);
		abortRun($sformatf("error at time %0t: %s is %0h, expected %0h", $time, what, got, exp));
	endtask

	// Whole run budget
	initial begin
		repeat (numIssued * cyclesPerInstr + 100) @(posedge clk);
		abortRun("Timeout: the DUT did not deliver all results in time");
	end

	// x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// Active-low gfedcba glyphs
	function automatic logic [6:0] segPattern(input logic [3:0] nib);
		logic [6:0] lit;
		case (nib)
			4'h0: lit = 7'h3F;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5B;
			4'h3: lit = 7'h4F;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6D;
			4'h6: lit = 7'h7D;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7F;
			4'h9: lit = 7'h67;
			4'hA: lit = 7'h77;
			4'hB: lit = 7'h7C;   // b
			4'hC: lit = 7'h58;   // c
			4'hD: lit = 7'h5E;   // d
			4'hE: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~lit;
	endfunction

	// Reference model, run in issue order
	function automatic void predict(input logic [3:0] op, input logic immSel,
			input logic [3:0] rdest, input logic [3:0] rsrc, input logic [swW-1:0] sw);
		logic [dataW-1:0] a;
		logic [dataW-1:0] b;
		logic [dataW-1:0] value;
		logic [flagW-1:0] flags;
		int sa;
		int sb;
		expEntry_t e;
		a = model[rdest];
		b = immSel ? {sw, 6'b000000} : model[rsrc];   // Immediate sits in the top bits
		sa = int'($signed(a));
		sb = int'($signed(b));
		flags = '0;
		case (op)
			ADD: begin
				value = a + b;
				flags[flagC] = (int'(a) + int'(b)) > 65535;
				flags[flagF] = (sa + sb > 32767) || (sa + sb < -32768);
			end
			SUB: begin
				value = a - b;
				flags[flagC] = a < b;   // Borrow
				flags[flagF] = (sa - sb > 32767) || (sa - sb < -32768);
			end
			CMP: value = a - b;        // Flags only, no write
			AND: value = a & b;
			OR: value = a | b;
			XOR: value = a ^ b;
			NOT: value = ~b;
			LSH: value = a << b[3:0];
			RSH: value = a >> b[3:0];
			default: value = b;
		endcase
		flags[flagL] = a < b;
		flags[flagN] = sa < sb;
		flags[flagZ] = (value == '0);
		e.res.rdest = rdest;
		e.res.value = value;
		e.res.flags = flags;
		e.res.writeEn = (op != CMP);
		if (e.res.writeEn) begin
			model[rdest] = value;
			shownModel = value;
		end
		e.shown = shownModel;
		pending.push_back(e);
	endfunction

	// Mask order {inst, imm, setup, reg}
	task automatic pressButton(input logic [3:0] mask, input logic [swW-1:0] word);
		@(negedge clk);
		dataIn = word;
		{ldInst, ldImm, ldSetup, ldReg} = ~mask;
		repeat (4) @(negedge clk);
		{ldInst, ldImm, ldSetup, ldReg} = 4'hF;
		repeat (4) @(negedge clk);   // Let the sync chain settle
	endtask

	task automatic loadAndIssue(input logic [3:0] op, input logic immSel,
			input logic [3:0] rdest, input logic [3:0] rsrc, input logic [swW-1:0] sw);
		pressButton(4'b0001, {rdest, 2'b00, rsrc});
		pressButton(4'b0010, {5'b00000, immSel, op});
		if (immSel) pressButton(4'b0100, sw);
		pressButton(4'b1000, dataIn);
		predict(op, immSel, rdest, rsrc, sw);
	endtask

	// Waits for a result, checks it, then takes it
	task automatic popResult();
		expEntry_t e;
		do @(negedge clk); while (!resultValid);
		assert (pending.size() > 0) else abortRun("A result came out with no instruction issued");
		e = pending.pop_front();
		assert (result.rdest == e.res.rdest)
			else valueError("rdest", 32'(result.rdest), 32'(e.res.rdest));
		assert (result.writeEn == e.res.writeEn)
			else valueError("writeEn", 32'(result.writeEn), 32'(e.res.writeEn));
		assert (result.value == e.res.value)
			else valueError("value", 32'(result.value), 32'(e.res.value));
		assert (result.flags == e.res.flags)
			else valueError("flags", 32'(result.flags), 32'(e.res.flags));
		assert ({seg3, seg2, seg1, seg0} == {segPattern(e.shown[15:12]),
				segPattern(e.shown[11:8]), segPattern(e.shown[7:4]), segPattern(e.shown[3:0])})
			else valueError("segments", 32'({seg3, seg2, seg1, seg0}), 32'(e.shown));
		resultReady = 1'b1;
		@(negedge clk);
		resultReady = 1'b0;
	endtask

	task automatic execute(input logic [3:0] op, input logic immSel,
			input logic [3:0] rdest, input logic [3:0] rsrc, input logic [swW-1:0] sw);
		loadAndIssue(op, immSel, rdest, rsrc, sw);
		popResult();
	endtask

	task automatic movImmediates();
		execute(MOV, 1'b1, 4'd1, 4'd0, 10'h3FF);   // 0xFFC0
		execute(MOV, 1'b1, 4'd2, 4'd0, 10'h001);   // 0x0040
		execute(MOV, 1'b1, 4'd3, 4'd0, 10'h200);   // 0x8000
		execute(MOV, 1'b1, 4'd4, 4'd0, 10'h1FF);   // 0x7FC0
		execute(MOV, 1'b1, 4'd5, 4'd0, 10'h155);
	endtask

	task automatic addSubFlags();
		execute(MOV, 1'b0, 4'd6, 4'd1, 10'h000);
		execute(ADD, 1'b0, 4'd6, 4'd2, 10'h000);   // Carry out, zero
		execute(SUB, 1'b0, 4'd7, 4'd2, 10'h000);   // Borrow from zero
		execute(ADD, 1'b0, 4'd4, 4'd4, 10'h000);   // Positive overflow
		execute(SUB, 1'b0, 4'd3, 4'd2, 10'h000);   // Negative overflow
		execute(SUB, 1'b0, 4'd5, 4'd5, 10'h000);
	endtask

	task automatic logicShiftCmp();
		execute(MOV, 1'b1, 4'd5, 4'd0, 10'h2D3);
		execute(AND, 1'b0, 4'd1, 4'd5, 10'h000);
		execute(OR, 1'b0, 4'd2, 4'd5, 10'h000);
		execute(XOR, 1'b0, 4'd3, 4'd5, 10'h000);
		execute(NOT, 1'b0, 4'd8, 4'd5, 10'h000);
		execute(MOV, 1'b1, 4'd9, 4'd0, 10'h3FF);
		execute(NOT, 1'b0, 4'd10, 4'd9, 10'h000);   // 0x003F, shift by 15
		execute(RSH, 1'b0, 4'd9, 4'd10, 10'h000);
		execute(LSH, 1'b0, 4'd8, 4'd9, 10'h000);
		execute(CMP, 1'b0, 4'd9, 4'd10, 10'h000);   // Display must hold
		execute(MOV, 1'b0, 4'd12, 4'd9, 10'h000);   // r9 untouched by CMP
	endtask

	// Output stalled, third word forwards from the second's write
	task automatic backPressure();
		loadAndIssue(MOV, 1'b1, 4'd13, 4'd0, 10'h0AB);
		loadAndIssue(ADD, 1'b0, 4'd13, 4'd13, 10'h000);
		loadAndIssue(MOV, 1'b0, 4'd14, 4'd13, 10'h000);
		repeat (3) popResult();
	endtask

	task automatic randomMix();
		logic [3:0] op;
		logic immSel;
		logic [3:0] rdest;
		logic [3:0] rsrc;
		logic [swW-1:0] sw;
		repeat (30) begin
			op = 4'(randBits(4));
			immSel = 1'(randBits(1));
			rdest = 4'(randBits(4));
			rsrc = 4'(randBits(4));
			sw = 10'(randBits(10));
			execute(op, immSel, rdest, rsrc, sw);
		end
	endtask

	initial begin
		rstN = 1'b0;
		dataIn = '0;
		{ldInst, ldImm, ldSetup, ldReg} = 4'hF;   // Released
		resultReady = 1'b0;
		lfsrState = 32'h57e6;
		shownModel = '0;
		for (int i = 0; i < numRegs; i++) begin
			model[i] = '0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		movImmediates();
		addSubFlags();
		logicShiftCmp();
		backPressure();
		randomMix();
		repeat (4) @(negedge clk);
		assert (!resultValid && pending.size() == 0)
			else abortRun("Result count does not match the issued instructions");
		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== regAluTop.sv ====
module regAluTop (
	input logic clk,
	input logic rstN,
	input logic [regAluPkg::swW-1:0] dataIn,
	input logic ldReg,
	input logic ldSetup,
	input logic ldImm,
	input logic ldInst,
	input logic resultReady,
	output logic resultValid,
	output regAluPkg::aluResult_t result,
	output logic [6:0] seg3,
	output logic [6:0] seg2,
	output logic [6:0] seg1,
	output logic [6:0] seg0
);
	import regAluPkg::*;

	// Capture to fetch
	logic cmdValid;
	logic cmdReady;
	aluCmd_t cmd;
	// Fetch to execute
	logic opValid;
	logic opReady;
	exOperands_t ops;
	// Register file ports
	logic [regAddrW-1:0] rdAddrA;
	logic [regAddrW-1:0] rdAddrB;
	logic [dataW-1:0] rdDataA;
	logic [dataW-1:0] rdDataB;
	logic wrEn;
	logic [regAddrW-1:0] wrAddr;
	logic [dataW-1:0] wrData;

	switchCapture capture (
		.clk(clk),
		.rstN(rstN),
		.dataIn(dataIn),
		.ldReg(ldReg),
		.ldSetup(ldSetup),
		.ldImm(ldImm),
		.ldInst(ldInst),
		.cmdReady(cmdReady),
		.cmdValid(cmdValid),
		.cmd(cmd)
	);

	operandFetch fetch (
		.clk(clk),
		.rstN(rstN),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.opReady(opReady),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.wrEn(wrEn),         // Bypass taps the write port
		.wrAddr(wrAddr),
		.wrData(wrData),
		.cmdReady(cmdReady),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.opValid(opValid),
		.ops(ops)
	);

	regFile rf (
		.clk(clk),
		.rstN(rstN),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB)
	);

	aluExec exec (
		.clk(clk),
		.rstN(rstN),
		.opValid(opValid),
		.ops(ops),
		.resultReady(resultReady),
		.opReady(opReady),
		.wrEn(wrEn),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.resultValid(resultValid),
		.result(result)
	);

	// Shown value is for probing only
	hexDisplay display (
		.clk(clk),
		.rstN(rstN),
		.wrEn(wrEn),
		.wrData(wrData),
		.shownValue(),
		.seg3(seg3),
		.seg2(seg2),
		.seg1(seg1),
		.seg0(seg0)
	);

endmodule

// ==== regAlu_checker.sv ====
module regAluChecker (
	input logic clk,
	input logic rstN,
	input logic cmdValid,
	input logic cmdReady,
	input logic resultValid,
	input logic resultReady,
	input regAluPkg::aluResult_t result
);

	// Output register empty while in reset
	resetClear: assert property (@(posedge clk) !rstN |-> !resultValid)
		else $error("resultValid high during reset");

	// Stalled result keeps valid and payload
	holdResult: assert property (@(posedge clk) disable iff (!rstN)
		resultValid && !resultReady |=> resultValid && $stable(result))
		else $error("result dropped or changed while stalled");

	holdCmd: assert property (@(posedge clk) disable iff (!rstN)
		cmdValid && !cmdReady |=> cmdValid)   // Capture must wait for fetch
		else $error("cmdValid dropped before cmdReady");

endmodule

bind regAluTop regAluChecker handshakeChk (
	.clk(clk),
	.rstN(rstN),
	.cmdValid(cmdValid),
	.cmdReady(cmdReady),
	.resultValid(resultValid),
	.resultReady(resultReady),
	.result(result)
);

// ==== regFile.sv ====
module regFile (
	input logic clk,
	input logic rstN,
	input logic [regAluPkg::regAddrW-1:0] rdAddrA,
	input logic [regAluPkg::regAddrW-1:0] rdAddrB,
	input logic wrEn,
	input logic [regAluPkg::regAddrW-1:0] wrAddr,
	input logic [regAluPkg::dataW-1:0] wrData,
	output logic [regAluPkg::dataW-1:0] rdDataA,
	output logic [regAluPkg::dataW-1:0] rdDataB
);
	import regAluPkg::*;

	logic [dataW-1:0] regs [numRegs];

	// Synchronous write
	// Contents start from zero after reset
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Asynchronous reads
	// Same-cycle write is not seen here, fetch forwards it
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

// ==== switchCapture.sv ====
module switchCapture (
	input logic clk,
	input logic rstN,
	input logic [regAluPkg::swW-1:0] dataIn,
	input logic ldReg,     // Buttons are active low
	input logic ldSetup,
	input logic ldImm,
	input logic ldInst,
	input logic cmdReady,
	output logic cmdValid,
	output regAluPkg::aluCmd_t cmd
);
	import regAluPkg::*;

	// Button vectors ordered {inst, imm, setup, reg}
	logic [3:0] btnMeta;
	logic [3:0] btnSync;
	logic [3:0] btnPrev;
	logic [3:0] btnFall;
	aluCmd_t fields;       // Working copy, updated at any time
	captState_t state;

	// Two-flop synchronizer plus one stage of history
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			btnMeta <= '1;     // Released buttons read high
			btnSync <= '1;
			btnPrev <= '1;
		end else begin
			btnMeta <= {ldInst, ldImm, ldSetup, ldReg};
			btnSync <= btnMeta;
			btnPrev <= btnSync;
		end
	end

	// One-cycle pulse per press
	assign btnFall = btnPrev & ~btnSync;

	// Field latches driven by the load buttons
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			fields <= '0;
		end else begin
			if (btnFall[0]) begin             // ldReg
				fields.rdest <= dataIn[9:6];
				fields.rsrc <= dataIn[3:0];
			end
			if (btnFall[1]) begin             // ldSetup
				fields.op <= aluOp_t'(dataIn[3:0]);
				fields.immSel <= dataIn[4];
			end
			if (btnFall[2]) begin             // ldImm, upper aligned
				fields.imm <= {dataIn, {(dataW - swW){1'b0}}};
			end
		end
	end

	// Issue FSM
	// Snapshot keeps cmd stable while it waits for the fetch stage
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= IDLE;
			cmd <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (btnFall[3]) begin
						cmd <= fields;
						state <= PENDING;
					end
				end
				PENDING: begin
					if (cmdReady) state <= IDLE;  // Press here is dropped
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign cmdValid = (state == PENDING);

endmodule
